// ==== cache_top.f ====
rtl/cache_pkg.sv
rtl/cache_if.sv
rtl/cache_req_buffer.sv
rtl/cache_ctrl.sv
rtl/cache_store.sv
rtl/cache_mem_port.sv
rtl/cache_top.sv
verification/cache_top_tb.sv

// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - rtl/cache_pkg.sv
  - rtl/cache_if.sv
  - rtl/cache_req_buffer.sv
  - rtl/cache_ctrl.sv
  - rtl/cache_store.sv
  - rtl/cache_mem_port.sv
  - rtl/cache_top.sv
  - target: simulation
    files:
      - verification/cache_top_tb.sv

// ==== verification/cache_top_tb.sv ====
`timescale 1ns/1ps

module cache_top_tb;
    import cache_pkg::*;

    localparam int req_total   = 300;
    localparam int cycle_limit = req_total * 40;

    // few tags over few sets, so both ways fill and evict often
    localparam logic [tag_width-1:0]   tag_pool [4] =
        '{20'h00001, 20'h0a5c3, 20'h7ff00, 20'hfffff};
    localparam logic [index_width-1:0] index_pool [4] = '{8'h00, 8'h6b, 8'h94, 8'hff};

    logic                    clk;
    logic                    resetn;
    logic                    valid;
    logic                    op;
    logic [index_width-1:0]  index;
    logic [tag_width-1:0]    tag;
    logic [offset_width-1:0] offset;
    logic [3:0]              wstrb;
    logic [31:0]             wdata;
    logic                    addr_ok;
    logic                    data_ok;
    logic [31:0]             rdata;
    logic                    rd_req;
    logic [31:0]             rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic                    ret_last;
    logic [31:0]             ret_data;
    logic                    wr_req;
    logic [31:0]             wr_addr;
    logic [line_width-1:0]   wr_data;
    logic                    wr_rdy;

    logic [7:0]  ref_bytes [logic [31:0]];      // every accepted store byte
    logic [31:0] mem_words [logic [31:0]];      // memory words after writebacks
    bit          written_lines [logic [31:0]];

    logic [31:0]            lfsr_state;
    logic                   req_op;
    logic [tag_width-1:0]   cur_tag;
    logic [index_width-1:0] cur_index;
    logic [31:0]            exp_rdata;
    logic [line_width-1:0]  exp_wr_line;
    logic                   wr_written;
    logic [31:0]            ret_base;
    int                     beats_left = 0;
    int                     beat_no = 0;
    logic                   acc_d1 = 0;
    logic                   acc_d2 = 0;
    logic                   dok_d1 = 0;
    logic                   outstanding = 0;    // accepted and waiting for data_ok
    logic                   miss_open = 0;      // memory traffic until ret_last
    int                     accept_count = 0;
    int                     dok_count = 0;
    int                     hit_count = 0;
    int                     wb_count = 0;
    int                     value_errors = 0;
    int                     protocol_errors = 0;
    int                     cycles;
    int                     sent;

    cache_top cache_top_inst (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return addr ^ 32'h3c96_a55a;
    endfunction

    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return fill_pattern(addr);
    endfunction

    // what a word should hold given all accepted stores
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] w;
        w = fill_pattern(addr);
        for (int i = 0; i < 4; i++) begin
            if (ref_bytes.exists(addr + 32'(i))) begin
                w[i*8 +: 8] = ref_bytes[addr + 32'(i)];
            end
        end
        return w;
    endfunction

    function automatic logic [line_width-1:0] line_contents(input logic [31:0] addr);
        logic [line_width-1:0] l;
        for (int b = 0; b < bank_count; b++) begin
            l[b*32 +: 32] = expected_word(addr + 32'(4 * b));   // bank 0 lowest
        end
        return l;
    endfunction

    task automatic record_store(input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                ref_bytes[addr + 32'(i)] = data[i*8 +: 8];
            end
        end
        written_lines[{addr[31:4], 4'h0}] = 1'b1;
    endtask

    task automatic issue_request();
        logic [31:0] addr;
        op     = 1'(rand_bits(1));
        tag    = tag_pool[2'(rand_bits(2))];
        index  = index_pool[2'(rand_bits(2))];
        offset = {2'(rand_bits(2)), 2'b00};
        wstrb  = 4'(rand_bits(4));
        if (wstrb == 4'h0) begin
            wstrb = 4'hf;
        end
        wdata     = rand_bits(32);
        valid     = 1'b1;
        addr      = {tag, index, offset};
        req_op    = op;
        cur_tag   = tag;
        cur_index = index;
        if (op) begin
            record_store(addr, wstrb, wdata);
        end else begin
            exp_rdata = expected_word(addr);
        end
    endtask

    // ready signals and beat gaps for the coming cycle
    task automatic serve_memory();
        rd_rdy = 1'(rand_bits(1));
        wr_rdy = 1'(rand_bits(1));
        if (beats_left > 0 && rand_bits(2) != 0) begin
            ret_valid = 1'b1;
            ret_data  = memory_word(ret_base + 32'(4 * beat_no));
            ret_last  = (beats_left == 1);
        end else begin
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
        if (wr_req) begin
            exp_wr_line = line_contents(wr_addr);
            wr_written  = written_lines.exists(wr_addr);
        end
    endtask

    task automatic report_counts();
        $display("requests %0d, value errors %0d, protocol errors %0d",
                 accept_count, value_errors, protocol_errors);
    endtask

    // memory side effects and transaction bookkeeping
    always @(posedge clk) begin
        if (!resetn) begin
            acc_d1      <= 1'b0;
            acc_d2      <= 1'b0;
            dok_d1      <= 1'b0;
            outstanding <= 1'b0;
            miss_open   <= 1'b0;
            beats_left  = 0;
        end else begin
            acc_d1 <= valid && addr_ok;
            acc_d2 <= acc_d1;
            dok_d1 <= data_ok;
            if (valid && addr_ok) begin
                outstanding <= 1'b1;
                accept_count++;
            end else if (data_ok) begin
                outstanding <= 1'b0;
            end
            if (data_ok) begin
                dok_count++;
            end
            if (acc_d2 && addr_ok) begin
                hit_count++;
            end
            if (rd_req || wr_req) begin
                miss_open <= 1'b1;
            end else if (ret_valid && ret_last) begin
                miss_open <= 1'b0;
            end
            if (wr_req && wr_rdy) begin
                wb_count++;
                for (int b = 0; b < bank_count; b++) begin
                    mem_words[wr_addr + 32'(4 * b)] = wr_data[b*32 +: 32];
                end
            end
            if (rd_req && rd_rdy) begin
                ret_base   = rd_addr;
                beats_left = 4;
                beat_no    = 0;
            end else if (ret_valid) begin
                beat_no++;
                beats_left--;
            end
        end
    end

    assert property (@(posedge clk) $rose(resetn) |-> addr_ok && !data_ok && !rd_req && !wr_req)
        else begin
            protocol_errors++;
            $display("Error at %0t: outputs not idle after reset", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) valid && addr_ok |=> !addr_ok)
        else begin
            protocol_errors++;
            $display("Error at %0t: addr_ok high right after an accept", $time);
        end

    // cycle n+2 is either idle again or already on the memory bus
    assert property (@(posedge clk) disable iff (!resetn)
                     valid && addr_ok |-> ##2 (addr_ok || rd_req || wr_req))
        else begin
            protocol_errors++;
            $display("Error at %0t: request neither finished nor went to memory", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn)
                     (miss_open || rd_req || wr_req || ret_valid) |-> !addr_ok)
        else begin
            protocol_errors++;
            $display("Error at %0t: addr_ok high while a refill is open", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) ret_valid && ret_last |=> addr_ok)
        else begin
            protocol_errors++;
            $display("Error at %0t: cache not idle after the last refill beat", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) data_ok && !req_op |-> rdata == exp_rdata)
        else begin
            value_errors++;
            $display("Error at %0t: rdata = %h, expected %h", $time, $sampled(rdata),
                     $sampled(exp_rdata));
        end

    assert property (@(posedge clk) disable iff (!resetn) data_ok |-> outstanding)
        else begin
            protocol_errors++;
            $display("Error at %0t: data_ok without an open request", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) valid && addr_ok |-> !outstanding)
        else begin
            protocol_errors++;
            $display("Error at %0t: new request accepted before data_ok", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) acc_d2 && addr_ok |-> dok_d1)
        else begin
            protocol_errors++;
            $display("Error at %0t: hit without data_ok one cycle after accept", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) acc_d1 && req_op |-> data_ok)
        else begin
            protocol_errors++;
            $display("Error at %0t: store without data_ok one cycle after accept", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn) wr_req |-> wr_data == exp_wr_line)
        else begin
            value_errors++;
            $display("Error at %0t: wr_data = %h, expected %h", $time, $sampled(wr_data),
                     $sampled(exp_wr_line));
        end

    // the victim sits in the requested set
    assert property (@(posedge clk) disable iff (!resetn)
                     wr_req |-> wr_addr[11:0] == {cur_index, 4'h0})
        else begin
            value_errors++;
            $display("Error at %0t: wr_addr[11:0] = %h, expected %h", $time,
                     $sampled(wr_addr[11:0]), {cur_index, 4'h0});
        end

    assert property (@(posedge clk) disable iff (!resetn)
                     wr_req |-> wr_written && wr_addr[31:12] != cur_tag)
        else begin
            protocol_errors++;
            $display("Error at %0t: writeback of a clean line or of the requested line", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn)
                     rd_req |-> rd_addr == {cur_tag, cur_index, 4'h0})
        else begin
            value_errors++;
            $display("Error at %0t: rd_addr = %h, expected %h", $time, $sampled(rd_addr),
                     {cur_tag, cur_index, 4'h0});
        end

    assert property (@(posedge clk) disable iff (!resetn)
                     rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            protocol_errors++;
            $display("Error at %0t: read request changed before rd_rdy", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn)
                     wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else begin
            protocol_errors++;
            $display("Error at %0t: write request changed before wr_rdy", $time);
        end

    initial begin : watchdog
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Error at %0t: run did not finish within %0d cycles", $time, cycle_limit);
        report_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        valid      = 1'b0;
        op         = 1'b0;
        index      = '0;
        tag        = '0;
        offset     = '0;
        wstrb      = '0;
        wdata      = '0;
        rd_rdy     = 1'b0;
        wr_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        ret_data   = '0;
        req_op     = 1'b0;
        lfsr_state = 32'hbaa0_0c02;
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        sent = 0;
        while (sent < req_total) begin
            @(negedge clk);
            serve_memory();
            if (addr_ok && rand_bits(2) != 0) begin     // idle gap about one time in four
                issue_request();
                sent++;
            end else begin
                valid = 1'b0;
            end
        end

        // let the last transaction drain
        do begin
            @(negedge clk);
            valid = 1'b0;
            serve_memory();
        end while (!(addr_ok && !outstanding && !miss_open));

        assert (accept_count == req_total && dok_count == req_total)
            else begin
                protocol_errors++;
                $display("Error at %0t: %0d requests accepted, %0d data_ok pulses", $time,
                         accept_count, dok_count);
            end

        assert (hit_count > 0 && wb_count > 0)
            else begin
                protocol_errors++;
                $display("Error at %0t: %0d hits and %0d writebacks seen in the run", $time,
                         hit_count, wb_count);
            end

        report_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                              clk,
    input  logic                              resetn,
    // processor side
    input  logic                              valid,
    input  logic                              op,
    input  logic [cache_pkg::index_width-1:0]  index,
    input  logic [cache_pkg::tag_width-1:0]    tag,
    input  logic [cache_pkg::offset_width-1:0] offset,
    input  logic [3:0]                        wstrb,
    input  logic [31:0]                       wdata,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [31:0]                       rdata,
    // memory read
    output logic                              rd_req,
    output logic [31:0]                       rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  logic                              ret_last,
    input  logic [31:0]                       ret_data,
    // memory write
    output logic                              wr_req,
    output logic [31:0]                       wr_addr,
    output logic [cache_pkg::line_width-1:0]   wr_data,
    input  logic                              wr_rdy
);
    import cache_pkg::*;

    logic                  accept;
    logic                  lookup;
    logic                  victim_way;
    logic                  fetch_start;
    logic                  hit;
    logic [31:0]           hit_word;
    logic                  victim_dirty;
    logic [tag_width-1:0]  victim_tag;
    logic [line_width-1:0] victim_line;

    cache_req_if    req_bus ();
    cache_refill_if refill_bus ();

    cache_req_buffer req_buffer_inst (
        .clk    (clk),
        .resetn (resetn),
        .accept (accept),
        .op     (op),
        .index  (index),
        .tag    (tag),
        .offset (offset),
        .wstrb  (wstrb),
        .wdata  (wdata),
        .req    (req_bus)
    );

    cache_ctrl ctrl_inst (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .hit         (hit),
        .hit_word    (hit_word),
        .req         (req_bus),
        .refill      (refill_bus),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .accept      (accept),
        .lookup      (lookup),
        .fetch_start (fetch_start),
        .victim_way  (victim_way)
    );

    cache_store store_inst (
        .clk          (clk),
        .resetn       (resetn),
        .accept       (accept),
        .lookup       (lookup),
        .victim_way   (victim_way),
        .index        (index),
        .req          (req_bus),
        .refill       (refill_bus),
        .hit          (hit),
        .hit_word     (hit_word),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line)
    );

    cache_mem_port mem_port_inst (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_start  (fetch_start),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .req          (req_bus),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_rdy       (wr_rdy),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .refill       (refill_bus)
    );

endmodule

// ==== rtl/cache_mem_port.sv ====
`timescale 1ns/1ps

module cache_mem_port (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             fetch_start,
    input  logic                             victim_dirty,
    input  logic [cache_pkg::tag_width-1:0]   victim_tag,
    input  logic [cache_pkg::line_width-1:0]  victim_line,
    cache_req_if.user                        req,
    input  logic                             rd_rdy,
    input  logic                             ret_valid,
    input  logic                             ret_last,
    input  logic [31:0]                      ret_data,
    input  logic                             wr_rdy,
    output logic                             rd_req,
    output logic [31:0]                      rd_addr,
    output logic                             wr_req,
    output logic [31:0]                      wr_addr,
    output logic [cache_pkg::line_width-1:0]  wr_data,
    cache_refill_if.port                     refill
);
    import cache_pkg::*;

    logic [tag_width-1:0]          wb_tag;
    logic [line_width-1:0]         wb_line;
    logic                          wb_pend;     // writeback outstanding
    logic                          rd_pend;     // line read not yet taken
    logic                          recv;        // waiting for beats
    logic [$clog2(bank_count)-1:0] beat_cnt;
    cache_addr_t                   rd_word;
    cache_addr_t                   wr_word;

    // victim copy, the arrays get overwritten by the refill
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            wb_tag  <= victim_tag;
            wb_line <= victim_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_pend  <= 1'b0;
            rd_pend  <= 1'b0;
            recv     <= 1'b0;
            beat_cnt <= '0;
        end else if (fetch_start) begin
            wb_pend  <= victim_dirty;
            rd_pend  <= 1'b1;
            beat_cnt <= '0;
        end else begin
            if (wr_req && wr_rdy) begin
                wb_pend <= 1'b0;
            end
            if (rd_req && rd_rdy) begin
                rd_pend <= 1'b0;
                recv    <= 1'b1;
            end
            if (refill.beat_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (ret_last) begin
                    recv <= 1'b0;
                end
            end
        end
    end

    // line addresses, offset always zero
    always_comb begin
        rd_word.fields.tag    = req.tag;
        rd_word.fields.index  = req.index;
        rd_word.fields.offset = '0;
        wr_word.fields.tag    = wb_tag;
        wr_word.fields.index  = req.index;
        wr_word.fields.offset = '0;
    end

    assign wr_req  = wb_pend;
    assign wr_addr = wr_word.raw;
    assign wr_data = wb_line;
    assign rd_req  = rd_pend && !wb_pend;   // read only after writeback
    assign rd_addr = rd_word.raw;

    assign refill.beat_valid = recv && ret_valid;
    assign refill.beat_bank  = beat_cnt;
    assign refill.beat_data  = ret_data;
    assign refill.beat_last  = recv && ret_valid && ret_last;

endmodule

// ==== rtl/cache_store.sv ====
`timescale 1ns/1ps

module cache_store (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             accept,
    input  logic                             lookup,
    input  logic                             victim_way,
    input  logic [cache_pkg::index_width-1:0] index,
    cache_req_if.user                        req,
    cache_refill_if.sink                     refill,
    output logic                             hit,
    output logic [31:0]                      hit_word,
    output logic                             victim_dirty,
    output logic [cache_pkg::tag_width-1:0]   victim_tag,
    output logic [cache_pkg::line_width-1:0]  victim_line
);
    import cache_pkg::*;

    logic [way_count-1:0][set_count-1:0] valid_bits;
    logic [way_count-1:0][set_count-1:0] dirty_bits;
    logic [tag_width-1:0] tag_rd [way_count];
    logic [31:0]          data_rd [way_count][bank_count];
    logic [way_count-1:0] way_hit;
    logic [way_count-1:0] hit_store;     // write hit, per way
    logic [1:0]           word;
    logic                 refill_done;
    logic                 store_merge;
    logic [31:0]          merge_word;
    logic [31:0]          bank_wdata;

    assign word        = req.offset[3:2];
    assign refill_done = refill.beat_valid && refill.beat_last;
    assign store_merge = req.op && (refill.beat_bank == word);

    // store bytes laid over the refill beat of a write miss
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merge_word[i*8 +: 8] = (store_merge && req.wstrb[i]) ? req.wdata[i*8 +: 8]
                                                                 : refill.beat_data[i*8 +: 8];
        end
    end

    assign bank_wdata = lookup ? req.wdata : merge_word;

    for (genvar w = 0; w < way_count; w++) begin : g_way
        logic [tag_width-1:0] tag_mem [set_count];

        assign way_hit[w]   = valid_bits[w][req.index] && (tag_rd[w] == req.tag);
        assign hit_store[w] = lookup && req.op && way_hit[w];

        always_ff @(posedge clk) begin
            if (refill_done && (victim_way == 1'(w))) begin
                tag_mem[req.index] <= req.tag;
            end
            if (accept) begin
                tag_rd[w] <= tag_mem[index];     // read with the incoming index
            end
        end

        for (genvar b = 0; b < bank_count; b++) begin : g_bank
            logic [31:0] data_mem [set_count];
            logic [3:0]  byte_we;

            assign byte_we = (hit_store[w] && (word == 2'(b))) ? req.wstrb
                           : (refill.beat_valid && (victim_way == 1'(w))
                              && (refill.beat_bank == 2'(b))) ? 4'hf
                           : 4'h0;

            always_ff @(posedge clk) begin
                for (int i = 0; i < 4; i++) begin
                    if (byte_we[i]) begin
                        data_mem[req.index][i*8 +: 8] <= bank_wdata[i*8 +: 8];
                    end
                end
                if (accept) begin
                    data_rd[w][b] <= data_mem[index];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            for (int w = 0; w < way_count; w++) begin
                if (hit_store[w]) begin
                    dirty_bits[w][req.index] <= 1'b1;
                end
            end
            if (refill_done) begin
                valid_bits[victim_way][req.index] <= 1'b1;
                dirty_bits[victim_way][req.index] <= req.op;  // write miss leaves it dirty
            end
        end
    end

    assign hit = |way_hit;

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < way_count; w++) begin
            if (way_hit[w]) begin
                hit_word = hit_word | data_rd[w][word];
            end
        end
    end

    // victim seen by the memory port during lookup
    assign victim_dirty = valid_bits[victim_way][req.index] && dirty_bits[victim_way][req.index];
    assign victim_tag   = tag_rd[victim_way];

    always_comb begin
        for (int b = 0; b < bank_count; b++) begin
            victim_line[b*32 +: 32] = data_rd[victim_way][b];   // bank 0 lowest
        end
    end

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic         clk,
    input  logic         resetn,
    input  logic         valid,
    input  logic         hit,
    input  logic [31:0]  hit_word,
    cache_req_if.user    req,
    cache_refill_if.sink refill,
    output logic         addr_ok,
    output logic         data_ok,
    output logic [31:0]  rdata,
    output logic         accept,
    output logic         lookup,
    output logic         fetch_start,
    output logic         victim_way
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic [7:0]  lfsr;
    logic        refill_done;
    logic        word_beat;

    assign refill_done = refill.beat_valid && refill.beat_last;
    // beat carrying the requested word
    assign word_beat = refill.beat_valid && (refill.beat_bank == req.offset[3:2]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= state_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            state_idle: begin
                if (accept) begin
                    state_next = state_lookup;
                end
            end
            state_lookup: begin
                state_next = hit ? state_idle : state_miss;
            end
            state_miss: begin
                if (refill_done) begin
                    state_next = state_idle;
                end
            end
            default: state_next = state_idle;
        endcase
    end

    assign addr_ok     = (state == state_idle);
    assign accept      = addr_ok && valid;
    assign lookup      = (state == state_lookup);
    assign fetch_start = lookup && !hit;        // one cycle, then miss

    // stores finish in lookup, read misses on the matching beat
    assign data_ok = (lookup && (hit || req.op))
                   || ((state == state_miss) && word_beat && !req.op);
    assign rdata   = lookup ? hit_word : refill.beat_data;

    // victim select, taps 7 5 4 3
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= lfsr_seed;
        end else if (refill_done) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign victim_way = lfsr[0];

endmodule

// ==== rtl/cache_req_buffer.sv ====
`timescale 1ns/1ps

module cache_req_buffer (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              accept,
    input  logic                              op,
    input  logic [cache_pkg::index_width-1:0]  index,
    input  logic [cache_pkg::tag_width-1:0]    tag,
    input  logic [cache_pkg::offset_width-1:0] offset,
    input  logic [3:0]                        wstrb,
    input  logic [31:0]                       wdata,
    cache_req_if.buffer                       req
);

    // op decides the dirty bit on refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req.op <= 1'b0;
        end else if (accept) begin
            req.op <= op;
        end
    end

    // address and store payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req.index  <= index;
            req.tag    <= tag;
            req.offset <= offset;
            req.wstrb  <= wstrb;
            req.wdata  <= wdata;
        end
    end

endmodule

// ==== rtl/cache_if.sv ====
`timescale 1ns/1ps

// request held for the whole transaction
interface cache_req_if;
    import cache_pkg::*;

    logic                    op;        // 1 = store
    logic [index_width-1:0]  index;
    logic [tag_width-1:0]    tag;
    logic [offset_width-1:0] offset;
    logic [3:0]              wstrb;
    logic [31:0]             wdata;

    modport buffer (output op, index, tag, offset, wstrb, wdata);
    modport user   (input  op, index, tag, offset, wstrb, wdata);
endinterface

// refill beats from memory, one word each
interface cache_refill_if;
    import cache_pkg::*;

    logic                          beat_valid;
    logic [$clog2(bank_count)-1:0] beat_bank;
    logic [31:0]                   beat_data;
    logic                          beat_last;

    modport port (output beat_valid, beat_bank, beat_data, beat_last);
    modport sink (input  beat_valid, beat_bank, beat_data, beat_last);
endinterface

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // cache geometry
    localparam int way_count    = 2;
    localparam int set_count    = 256;
    localparam int bank_count   = 4;    // 32-bit words per line
    localparam int index_width  = 8;
    localparam int tag_width    = 20;
    localparam int offset_width = 4;
    localparam int line_width   = 128;

    // victim LFSR reset value, must be nonzero
    localparam logic [7:0] lfsr_seed = 8'h01;

    // one address word, seen either as a bus word or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_width-1:0]    tag;
            logic [index_width-1:0]  index;
            logic [offset_width-1:0] offset;  // word select in 3:2
        } fields;
    } cache_addr_t;

    typedef enum logic [1:0] {
        state_idle,
        state_lookup,
        state_miss
    } ctrl_state_t;

endpackage
